// ==== hw/led_status_pkg.sv ====
package led_status_pkg;

  localparam int num_src             = 8;        // error sources, one flag each
  localparam int code_w              = 4;        // blink code width
  localparam int blink_slots         = 4;        // one bit per slot
  localparam int gap_slots           = 2;        // dark slots between codes
  localparam int default_slot_cycles = 12288000; // one second at 12.288 MHz

  localparam int src_w      = $clog2(num_src);
  localparam int slot_cnt_w = $clog2(blink_slots);

  localparam logic [src_w-1:0]      last_src        = src_w'(num_src - 1);
  localparam logic [slot_cnt_w-1:0] last_blink_slot = slot_cnt_w'(blink_slots - 1);
  localparam logic [slot_cnt_w-1:0] last_gap_slot   = slot_cnt_w'(gap_slots - 1);

  // word addresses
  localparam logic [3:0] adr_status = 4'd0; // flags, write one to clear
  localparam logic [3:0] adr_mask   = 4'd1; // 1 enables a source
  localparam logic [3:0] adr_force  = 4'd2; // write one to set, reads zero
  localparam logic [3:0] adr_blink  = 4'd3; // coder status, read only

  typedef logic [num_src-1:0] err_vec_t;

  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic        we;
    logic [3:0]  adr; // word address
    logic [31:0] dat;
  } wb_m2s_t;

  typedef struct packed {
    logic        ack;
    logic [31:0] dat;
  } wb_s2m_t;

  typedef struct packed {
    logic              active;   // code or gap in progress
    logic [code_w-1:0] code;     // index being shown
    logic [7:0]        done_cnt; // finished codes, wraps
  } blink_stat_t;

endpackage

// ==== hw/err_latch.sv ====
`timescale 1ns/10ps

module err_latch
  import led_status_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  err_vec_t err_in,     // hardware strobes
  input  err_vec_t mask,       // 0 blocks a source
  input  err_vec_t force_set,  // software set pulse
  input  err_vec_t sw_clear,   // software clear pulse
  input  err_vec_t report_clr, // clear after the code was shown
  output err_vec_t flags
);

  err_vec_t set_vec;
  err_vec_t clr_vec;
  err_vec_t flags_q;

  // a masked source never latches, but software can still force it
  assign set_vec = (err_in & mask) | force_set;
  assign clr_vec = sw_clear | report_clr;

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      flags_q <= '0;
    end
    else
    begin
      flags_q <= (flags_q & ~clr_vec) | set_vec; // set wins over clear
    end
  end

  assign flags = flags_q;

  // the coder reports one source at a time
  report_clr_onehot: assert property (
    @(posedge clk) disable iff (reset)
    $onehot0(report_clr)
  )
  else
    $error("report_clr is not one-hot: %b", report_clr);

endmodule

// ==== hw/blink_coder.sv ====
`timescale 1ns/10ps

module blink_coder
  import led_status_pkg::*;
#(
  parameter int slot_cycles = default_slot_cycles // slot is slot_cycles+1 clocks
) (
  input  logic        clk,
  input  logic        reset,
  input  err_vec_t    flags,
  output err_vec_t    report_clr,
  output blink_stat_t blink,
  output logic        led_off
);

  localparam int tmr_w = $clog2(slot_cycles + 1);

  localparam logic [tmr_w-1:0] tmr_max = tmr_w'(slot_cycles);
  localparam logic [tmr_w-1:0] one_lo  = tmr_w'(slot_cycles / 10);      // long pulse
  localparam logic [tmr_w-1:0] one_hi  = tmr_w'((slot_cycles * 9) / 10);
  localparam logic [tmr_w-1:0] zero_lo = tmr_w'((slot_cycles * 4) / 10); // short pulse
  localparam logic [tmr_w-1:0] zero_hi = tmr_w'((slot_cycles * 5) / 10);

  typedef enum logic [1:0] {
    st_find,  // round-robin scan of the flags
    st_blink, // code shown LSB first
    st_next,  // one cycle, clear the reported flag
    st_wait   // dark gap
  } state_t;

  state_t                state;
  logic [tmr_w-1:0]      slot_tmr;
  logic [slot_cnt_w-1:0] slot_cnt;
  logic [src_w-1:0]      rr_ptr;   // source under test, then source shown
  logic [code_w-1:0]     code_q;
  logic [code_w-1:0]     code_sr;  // bit 0 is the current slot
  logic [7:0]            done_cnt;
  logic                  slot_end;
  logic                  in_one;
  logic                  in_zero;
  logic                  lit;

  assign slot_end = (slot_tmr == tmr_max);

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state    <= st_find;
      slot_tmr <= '0;
      slot_cnt <= '0;
      rr_ptr   <= '0;
      code_q   <= '0;
      code_sr  <= '0;
      done_cnt <= '0;
    end
    else
    begin
      slot_tmr <= slot_end ? '0 : slot_tmr + 1'b1; // free running

      case (state)
        st_find:
        begin
          if (flags[rr_ptr])
          begin
            code_q   <= code_w'(rr_ptr);
            code_sr  <= code_w'(rr_ptr);
            slot_tmr <= '0; // first slot starts now
            slot_cnt <= '0;
            state    <= st_blink;
          end
          else
          begin
            rr_ptr <= (rr_ptr == last_src) ? '0 : rr_ptr + 1'b1;
          end
        end

        st_blink:
        begin
          if (slot_end)
          begin
            code_sr <= code_sr >> 1;
            if (slot_cnt == last_blink_slot)
            begin
              state <= st_next;
            end
            else
            begin
              slot_cnt <= slot_cnt + 1'b1;
            end
          end
        end

        st_next:
        begin
          done_cnt <= done_cnt + 1'b1;
          rr_ptr   <= (rr_ptr == last_src) ? '0 : rr_ptr + 1'b1; // resume after it
          slot_cnt <= '0;
          state    <= st_wait;
        end

        st_wait:
        begin
          if (slot_end)
          begin
            if (slot_cnt == last_gap_slot)
            begin
              state <= st_find;
            end
            else
            begin
              slot_cnt <= slot_cnt + 1'b1;
            end
          end
        end

        default:
        begin
          state <= st_find;
        end
      endcase
    end
  end

  assign in_one  = (slot_tmr >= one_lo) && (slot_tmr <= one_hi);
  assign in_zero = (slot_tmr >= zero_lo) && (slot_tmr <= zero_hi);
  assign lit     = (state == st_blink) && (code_sr[0] ? in_one : in_zero);
  assign led_off = ~lit;

  assign report_clr = (state == st_next) ? (err_vec_t'(1'b1) << rr_ptr) : '0;

  assign blink.active   = (state != st_find);
  assign blink.code     = code_q;
  assign blink.done_cnt = done_cnt;

  code_in_range: assert property (
    @(posedge clk) disable iff (reset)
    blink.code < code_w'(num_src)
  )
  else
    $error("blink code %0d out of range", blink.code);

endmodule

// ==== hw/wb_err_regs.sv ====
`timescale 1ns/10ps

module wb_err_regs
  import led_status_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  wb_m2s_t     wb_in,
  output wb_s2m_t     wb_out,
  input  err_vec_t    flags,
  input  blink_stat_t blink,
  output err_vec_t    mask,
  output err_vec_t    force_set,
  output err_vec_t    sw_clear
);

  logic        ack_q;
  logic [31:0] dat_q;
  logic        req;
  logic        wr;
  logic [31:0] rd_data;
  err_vec_t    mask_q;

  // new request, sampled at the edge that raises ack
  assign req = wb_in.cyc & wb_in.stb & ~ack_q;
  assign wr  = req & wb_in.we;

  // pulses land in the flags at the same edge as ack
  assign force_set = (wr && (wb_in.adr == adr_force)) ? wb_in.dat[num_src-1:0] : '0;
  assign sw_clear  = (wr && (wb_in.adr == adr_status)) ? wb_in.dat[num_src-1:0] : '0;

  always_comb
  begin
    rd_data = '0; // force and unmapped words read zero
    case (wb_in.adr)
      adr_status:
      begin
        rd_data[num_src-1:0] = flags;
      end
      adr_mask:
      begin
        rd_data[num_src-1:0] = mask_q;
      end
      adr_blink:
      begin
        rd_data[4]    = blink.active;
        rd_data[3:0]  = blink.code;
        rd_data[15:8] = blink.done_cnt;
      end
      default:
      begin
        rd_data = '0;
      end
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      ack_q  <= 1'b0;
      mask_q <= '1; // all sources enabled
    end
    else
    begin
      ack_q <= req; // one cycle, never stalls
      if (wr && (wb_in.adr == adr_mask))
      begin
        mask_q <= wb_in.dat[num_src-1:0];
      end
    end
  end

  always_ff @(posedge clk)
  begin
    dat_q <= req ? rd_data : '0;
  end

  assign mask       = mask_q;
  assign wb_out.ack = ack_q;
  assign wb_out.dat = dat_q;

  ack_needs_request: assert property (
    @(posedge clk) disable iff (reset)
    wb_out.ack |-> $past(wb_in.cyc && wb_in.stb)
  )
  else
    $error("ack without a request in the previous cycle");

endmodule

// ==== hw/led_status_top.sv ====
`timescale 1ns/10ps

module led_status_top
  import led_status_pkg::*;
#(
  parameter int slot_cycles = default_slot_cycles
) (
  input  logic     clk,
  input  logic     reset,
  input  err_vec_t err_in,  // error strobes
  input  wb_m2s_t  wb_in,
  output wb_s2m_t  wb_out,
  output logic     led_off  // high is dark
);

  err_vec_t    flags;
  err_vec_t    mask;
  err_vec_t    force_set;
  err_vec_t    sw_clear;
  err_vec_t    report_clr;
  blink_stat_t blink;

  err_latch err_latch_inst (
    .clk        (clk),
    .reset      (reset),
    .err_in     (err_in),
    .mask       (mask),
    .force_set  (force_set),
    .sw_clear   (sw_clear),
    .report_clr (report_clr),
    .flags      (flags)
  );

  blink_coder #(
    .slot_cycles (slot_cycles)
  ) blink_coder_inst (
    .clk        (clk),
    .reset      (reset),
    .flags      (flags),
    .report_clr (report_clr),
    .blink      (blink),
    .led_off    (led_off)
  );

  wb_err_regs wb_err_regs_inst (
    .clk       (clk),
    .reset     (reset),
    .wb_in     (wb_in),
    .wb_out    (wb_out),
    .flags     (flags),
    .blink     (blink),
    .mask      (mask),
    .force_set (force_set),
    .sw_clear  (sw_clear)
  );

endmodule

// ==== tests/led_status_tb.sv ====
`timescale 1ns/10ps

module led_status_tb
  import led_status_pkg::*;
();

  logic        clk;
  logic        reset;
  err_vec_t    err_in;
  wb_m2s_t     wb_in;
  wb_s2m_t     wb_out;
  logic        led_off;

  integer      seed = 32'h2251_84a8;
  int          errors;
  err_vec_t    m_flags;      // model flags
  err_vec_t    m_mask;       // model mask
  logic [3:0]  last_code;    // last reported index
  int          pulse_len;
  logic [3:0]  code_shift;
  int          nbits;
  int          decoded;      // codes seen on the LED
  logic [3:0]  codes[$];

  led_status_top #(
    .slot_cycles (100)
  ) led_status_top_inst (
    .clk     (clk),
    .reset   (reset),
    .err_in  (err_in),
    .wb_in   (wb_in),
    .wb_out  (wb_out),
    .led_off (led_off)
  );

  always #50 clk = ~clk;

  // LED pulse decoder, long pulse is a 1, four bits LSB first
  always @(posedge clk)
  begin
    if (reset)
    begin
      pulse_len <= 0;
      nbits     <= 0;
      decoded   <= 0;
    end
    else if (!led_off)
    begin
      pulse_len <= pulse_len + 1;
    end
    else if (pulse_len > 0)
    begin
      pulse_len <= 0;
      if (nbits == 3)
      begin
        codes.push_back({pulse_len > 40, code_shift[3:1]});
        decoded <= decoded + 1;
        nbits   <= 0;
      end
      else
      begin
        code_shift <= {pulse_len > 40, code_shift[3:1]};
        nbits      <= nbits + 1;
      end
    end
  end

  task automatic check_flags(input string name, input err_vec_t exp, input err_vec_t act);
    if (exp !== act)
    begin
      $display("CHECK FAILED %s expected %b actual %b", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_word(input string name, input logic [31:0] exp,
                            input logic [31:0] act);
    if (exp !== act)
    begin
      $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_code(input string name, input logic [3:0] exp, input logic [3:0] act);
    if (exp !== act)
    begin
      $display("CHECK FAILED %s expected %0d actual %0d", name, exp, act);
      errors++;
    end
  endtask

  task automatic report_timeout(input string what);
    $display("timeout while waiting for %s", what);
    errors++;
  endtask

  // one Wishbone access, with an optional error strobe in the request cycle
  task automatic bus_access(input logic we, input logic [3:0] adr, input logic [31:0] dat,
                            input err_vec_t strobe, output logic [31:0] rdata);
    int       n;
    err_vec_t held; // strobes that outlast the access
    n = 0;
    @(negedge clk);
    held      = err_in;
    wb_in.cyc = 1'b1;
    wb_in.stb = 1'b1;
    wb_in.we  = we;
    wb_in.adr = adr;
    wb_in.dat = dat;
    err_in    = held | strobe;
    @(negedge clk);
    err_in = held;
    while (!wb_out.ack && n < 50)
    begin
      n++;
      @(negedge clk);
    end
    if (!wb_out.ack)
    begin
      report_timeout("ack");
    end
    rdata = wb_out.dat;
    wb_in = '0;
  endtask

  task automatic reg_write(input logic [3:0] adr, input logic [31:0] dat,
                           input err_vec_t strobe);
    logic [31:0] unused;
    err_vec_t    set_vec;
    set_vec = strobe & m_mask; // mask in effect before the write
    bus_access(1'b1, adr, dat, strobe, unused);
    case (adr)
      adr_status: m_flags = (m_flags & ~dat[num_src-1:0]) | set_vec;
      adr_mask:
      begin
        m_flags = m_flags | set_vec;
        m_mask  = dat[num_src-1:0];
      end
      adr_force:  m_flags = m_flags | dat[num_src-1:0] | set_vec;
      default:    m_flags = m_flags | set_vec;
    endcase
  endtask

  task automatic reg_read(input logic [3:0] adr, output logic [31:0] rdata);
    bus_access(1'b0, adr, 32'd0, '0, rdata);
  endtask

  task automatic strobe_only(input err_vec_t e);
    @(negedge clk);
    err_in = e;
    @(negedge clk);
    err_in  = '0;
    m_flags = m_flags | (e & m_mask);
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(negedge clk);
  endtask

  task automatic wait_code(output logic [3:0] code);
    int n;
    n    = 0;
    code = '0;
    while (codes.size() == 0 && n < 3000)
    begin
      n++;
      @(negedge clk);
    end
    if (codes.size() == 0)
    begin
      report_timeout("an LED code");
    end
    else
    begin
      code = codes.pop_front();
    end
  endtask

  // done_cnt catches up with the codes seen on the LED
  task automatic wait_report();
    logic [31:0] bl;
    int          n;
    n = 0;
    reg_read(adr_blink, bl);
    while (bl[15:8] != 8'(decoded) && n < 100)
    begin
      n++;
      reg_read(adr_blink, bl);
    end
    if (bl[15:8] != 8'(decoded))
    begin
      report_timeout("the report of a code");
    end
  endtask

  // no flags and no code or gap in progress
  task automatic wait_quiet();
    logic [31:0] st;
    logic [31:0] bl;
    int          n;
    n = 0;
    reg_read(adr_status, st);
    reg_read(adr_blink, bl);
    while ((st != 0 || bl[4]) && n < 100)
    begin
      n++;
      wait_cycles(20);
      reg_read(adr_status, st);
      reg_read(adr_blink, bl);
    end
    if (st != 0 || bl[4])
    begin
      report_timeout("an idle coder");
    end
    m_flags = '0;
  endtask

  function automatic logic [3:0] next_set(input err_vec_t f, input int from);
    int idx;
    for (int i = 1; i <= num_src; i++)
    begin
      idx = (from + i) % num_src;
      if (f[idx])
      begin
        return 4'(idx);
      end
    end
    return 4'd0;
  endfunction

  task automatic check_blink_reg(input string name);
    logic [31:0] rd;
    reg_read(adr_blink, rd);
    check_word(name, {16'd0, 8'(decoded), 3'd0, 1'b0, last_code}, rd);
  endtask

  initial
  begin
    logic [31:0] rd;
    logic [31:0] r;
    err_vec_t    d;
    err_vec_t    e;
    logic [3:0]  code;
    int          n_codes;
    int          src;
    int          n;
    clk     = 1'b0;
    reset   = 1'b1;
    err_in  = '0;
    wb_in   = '0;
    errors  = 0;
    m_flags = '0;
    m_mask  = '1;
    last_code = '0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    // test 1, reset values
    reg_read(adr_status, rd);
    check_word("reset status", 32'd0, rd);
    reg_read(adr_mask, rd);
    check_word("reset mask", 32'h0000_00ff, rd);
    reg_read(adr_blink, rd);
    check_word("reset blink", 32'd0, rd);
    n = 0;
    repeat (1000)
    begin
      @(negedge clk);
      if (!led_off)
      begin
        n++;
      end
    end
    if (n != 0)
    begin
      $display("LED lit for %0d cycles with no flag set", n);
      errors++;
    end

    // test 2, mask writes and strobes, short enough that no report finishes
    for (int i = 0; i < 20; i++)
    begin
      r = $random(seed);
      if (r[0])
      begin
        reg_write(adr_mask, {24'd0, r[15:8]}, '0);
      end
      strobe_only(r[23:16]);
      reg_read(adr_status, rd);
      check_flags("masked strobes", m_flags, rd[num_src-1:0]);
    end

    // test 3, write one to clear racing strobes, then force
    for (int i = 0; i < 6; i++)
    begin
      r = $random(seed);
      d = r[7:0];
      e = d & r[15:8]; // overlap the cleared bits
      reg_write(adr_status, {24'd0, d}, e);
      reg_read(adr_status, rd);
      check_flags("w1c status", m_flags, rd[num_src-1:0]);
      reg_write(adr_force, {24'd0, r[23:16]}, '0);
      reg_read(adr_status, rd);
      check_flags("force status", m_flags, rd[num_src-1:0]);
    end
    reg_read(adr_force, rd);
    check_word("force reads zero", 32'd0, rd);
    reg_write(adr_mask, 32'h0000_00ff, '0);
    reg_write(adr_status, 32'h0000_00ff, '0);
    wait_quiet();
    if (codes.size() > 0)
    begin
      last_code = codes[codes.size()-1];
    end
    codes.delete();
    check_blink_reg("blink after cleanup");

    // test 4, round-robin order of forced flags
    r = $random(seed);
    d = (r[7:0] | 8'h10) & 8'hfe;
    reg_write(adr_force, 32'd1, '0); // source 0 alone, the scan must find it
    n_codes = $countones(d) + 1;
    for (int i = 0; i < n_codes; i++)
    begin
      wait_code(code);
      if (i == 0)
      begin
        check_code("round robin", 4'd0, code);
        reg_write(adr_force, {24'd0, d}, '0); // rest lands while source 0 blinks
      end
      else
      begin
        check_code("round robin", next_set(m_flags, int'(last_code)), code);
      end
      m_flags[code] = 1'b0;
      last_code     = code;
      wait_report();
      reg_read(adr_status, rd);
      check_flags("status after report", m_flags, rd[num_src-1:0]);
    end
    wait_quiet();
    check_blink_reg("done count");

    // test 5, strobe during its own blink survives the clear
    src = $random(seed) & 7;
    reg_write(adr_force, 32'd1 << src, '0);
    wait_code(code);
    check_code("first report", 4'(src), code);
    err_in  = err_vec_t'(1) << src; // held through the clear of its own code
    m_flags = m_flags | (err_in & m_mask);
    wait_report();
    err_in    = '0;
    last_code = code;
    reg_read(adr_status, rd);
    check_flags("flag kept", m_flags, rd[num_src-1:0]);
    wait_code(code);
    check_code("second report", next_set(m_flags, src), code);
    m_flags[code] = 1'b0;
    last_code     = code;
    wait_report();
    reg_read(adr_status, rd);
    check_flags("flag gone", m_flags, rd[num_src-1:0]);
    wait_quiet();
    check_blink_reg("done count again");

    // test 6, unmapped words
    reg_write(adr_mask, 32'h0000_005a, '0);
    for (int a = 4; a < 16; a++)
    begin
      reg_read(4'(a), rd);
      check_word("unmapped read", 32'd0, rd);
      reg_write(4'(a), $random(seed), '0);
    end
    reg_read(adr_status, rd);
    check_flags("status after unmapped", m_flags, rd[num_src-1:0]);
    reg_read(adr_mask, rd);
    check_flags("mask after unmapped", m_mask, rd[num_src-1:0]);
    check_blink_reg("blink after unmapped");

    $display("errors: %0d", errors);
    if (errors == 0)
    begin
      $display("Testbench passed");
    end
    else
    begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// ==== led_status.f ====
hw/led_status_pkg.sv
hw/err_latch.sv
hw/blink_coder.sv
hw/wb_err_regs.sv
hw/led_status_top.sv
tests/led_status_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the led_status testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f led_status.f \
  --top-module led_status_tb \
  -o led_status_sim

sim_out=$(./obj_dir/led_status_sim)
echo "$sim_out"

if echo "$sim_out" | grep -q "Testbench passed"; then
  exit 0
else
  exit 1
fi
